// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= tb_exmem_slice
FILELIST  ?= vlog.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | awk '{ print } /^TEST PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: bench/clock_gen.sv
/* free-running 100 ns clock; reset is high for the first 8 rising edges */
`timescale 1ns/1ps

module clock_gen (
    output logic o_clk,
    output logic o_reset
);
    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 8;

    initial begin
        o_clk   = 1'b0;
        o_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        // release on the edge so that the DUT sees a clean level
        o_reset <= 1'b0;
    end

    always #(HALF_PERIOD) o_clk = ~o_clk;

endmodule

// File: bench/tb_exmem_slice.sv
/* random ops from a fixed-seed LFSR, checked against an in-order model of the slice
   outputs are sampled on the falling edge, inputs change on the rising edge */
`timescale 1ns/1ps

module tb_exmem_slice;
    import alu_pkg::*;
    import mem_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int N_ALU = 60;
    localparam int N_LINK = 40;
    localparam int N_MEM = 80;
    localparam int N_MIS = 24;
    localparam int N_STALL = 60;
    localparam int TOTAL_OPS = N_ALU + N_LINK + N_MEM + N_MIS + N_STALL;
    localparam int CYCLE_LIMIT = 4 * TOTAL_OPS + RESET_CYCLES;

    logic clk;
    logic rst;
    logic i_valid;
    logic i_stall;
    logic [OP_W-1:0] i_op;
    logic [WORD_W-1:0] i_rs_val;
    logic [WORD_W-1:0] i_rt_val;
    logic [WORD_W-1:0] i_imm;
    logic i_use_imm;
    logic [REG_W-1:0] i_target;
    logic [WORD_W-1:0] i_pc;
    logic [SIZE_W-1:0] i_size;
    logic i_load_sign;
    logic o_wb_valid;
    logic o_wb_reg_write;
    logic [REG_W-1:0] o_wb_reg;
    logic [WORD_W-1:0] o_wb_data;
    logic o_exc;
    logic [CAUSE_W-1:0] o_exc_cause;

    // model state: memory copy and the queue of pending write-backs
    logic [WORD_W-1:0] model_mem [MEM_WORDS];
    string name_q [$];
    logic [WORD_W-1:0] data_q [$];
    logic [REG_W-1:0] reg_q [$];
    logic [CAUSE_W-1:0] cause_q [$];
    logic write_q [$];
    logic exc_q [$];
    logic check_data_q [$];

    logic [31:0] lfsr_state = 32'd76131;
    string cur_test;
    int stall_bits;
    int errors = 0;
    int checks = 0;
    int ops_done = 0;
    int cycles = 0;

    clock_gen u_clock (.o_clk(clk), .o_reset(rst));

    exmem_slice i_dut (.clk(clk), .i_reset(rst), .*);

    // taps 32, 22, 2, 1
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", test, what, expected, actual);
        end
    endtask

    // held stall cycles carry garbage that must be ignored
    task automatic insert_stalls();
        while (rand_bits(stall_bits) == 0) begin
            @(posedge clk);
            i_stall <= 1'b1;
            i_valid <= rand_bit();
            i_op    <= OP_W'(rand_bits(4));
        end
    endtask

    task automatic issue_op(input logic [3:0] op, input logic [31:0] rs, input logic [31:0] rt,
                            input logic [31:0] imm, input logic use_imm,
                            input logic [4:0] target, input logic [1:0] size, input logic sign);
        logic [31:0] pc;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] w;
        logic [32:0] wide;
        logic [4:0] sh;
        logic [7:0] by;
        logic [15:0] hf;
        logic ovf;
        logic mis;
        pc = rand_bits(30) << 2;
        insert_stalls();
        @(posedge clk);
        i_stall     <= 1'b0;
        i_valid     <= 1'b1;
        i_op        <= op;
        i_rs_val    <= rs;
        i_rt_val    <= rt;
        i_imm       <= imm;
        i_use_imm   <= use_imm;
        i_target    <= target;
        i_pc        <= pc;
        i_size      <= size;
        i_load_sign <= sign;
        // expected result from the instruction rules
        b    = use_imm ? imm : rt;
        sh   = imm[SHAMT_MSB:SHAMT_LSB];
        addr = rs + imm;
        ovf  = 1'b0;
        mis  = (op == OP_LOAD || op == OP_STORE) && size == SIZE_HALF && addr[0];
        case (op)
            OP_ADD, OP_ADDU: begin
                res  = rs + b;
                wide = {rs[31], rs} + {b[31], b};
                ovf  = (op == OP_ADD) && (wide[32] != wide[31]);
            end
            OP_SUB, OP_SUBU: begin
                res  = rs - b;
                wide = {rs[31], rs} - {b[31], b};
                ovf  = (op == OP_SUB) && (wide[32] != wide[31]);
            end
            OP_AND:  res = rs & b;
            OP_OR:   res = rs | b;
            OP_XOR:  res = rs ^ b;
            OP_NOR:  res = ~(rs | b);
            OP_SLL:  res = b << sh;
            OP_SRL:  res = b >> sh;
            OP_SRA:  res = $signed(b) >>> sh;
            OP_SLT:  res = {31'd0, $signed(rs) < $signed(b)};
            OP_SLTU: res = {31'd0, rs < b};
            OP_LINK: res = pc + 32'd4;
            default: res = addr;
        endcase
        w  = model_mem[addr[7:2]];
        by = w[8 * addr[1:0] +: 8];
        hf = w[16 * addr[1] +: 16];
        if (op == OP_STORE && !mis) begin
            if (size == SIZE_BYTE) w[8 * addr[1:0] +: 8] = rt[7:0];
            else if (size == SIZE_HALF) w[16 * addr[1] +: 16] = rt[15:0];
            else w = rt;
            model_mem[addr[7:2]] = w;
        end else if (op == OP_LOAD) begin
            if (size == SIZE_BYTE) res = sign ? {{24{by[7]}}, by} : {24'd0, by};
            else if (size == SIZE_HALF) res = sign ? {{16{hf[15]}}, hf} : {16'd0, hf};
            else res = w;
        end
        name_q.push_back(cur_test);
        data_q.push_back(res);
        reg_q.push_back(op == OP_LINK ? 5'd31 : target);
        write_q.push_back(op != OP_STORE && !ovf && !mis);
        exc_q.push_back(ovf || mis);
        cause_q.push_back(ovf ? CAUSE_OVERFLOW : (mis ? CAUSE_MISALIGNED : CAUSE_NONE));
        check_data_q.push_back(op != OP_STORE && !ovf && !mis);
        ops_done++;
    endtask

    // kind 0 alu, 1 link and overflow, 2 store/load, 3 misaligned, other mixed
    task automatic random_op(input int kind);
        logic [3:0] op;
        logic [31:0] rs;
        logic [15:0] imm_low;
        logic [31:0] imm;
        logic [31:0] sum;
        logic [1:0] size;
        int k;
        rs      = rand_bits(32);
        // sign-extended 16-bit immediate
        imm_low = 16'(rand_bits(16));
        imm     = {{16{imm_low[15]}}, imm_low};
        size = 2'(rand_bits(2));
        if (size == 2'd3) size = SIZE_WORD;
        k = int'(rand_bits(3) % 5);
        case (kind)
            0: begin
                do op = 4'(rand_bits(4)); while (op > OP_SLTU);
            end
            1: op = (k == 0) ? OP_LINK : (k == 1) ? OP_ADD : (k == 2) ? OP_SUB :
                    (k == 3) ? OP_ADDU : OP_SUBU;
            2: op = rand_bit() ? OP_STORE : OP_LOAD;
            3: begin
                k    = k % 3;
                op   = (k == 0) ? OP_STORE : OP_LOAD;
                size = (k < 2) ? SIZE_HALF : SIZE_WORD;
            end
            default: op = 4'(rand_bits(4));
        endcase
        if (op == OP_LOAD || op == OP_STORE) begin
            // keep accesses in a few words so loads see earlier stores
            rs  = 32'(rand_bits(4));
            imm = 32'(rand_bits(3));
            sum = rs + imm;
            if (size == SIZE_HALF && sum[0] != (kind == 3 && k < 2)) rs = rs ^ 32'd1;
        end
        issue_op(op, rs, rand_bits(32), imm, rand_bit(), 5'(rand_bits(5)), size, rand_bit());
    endtask

    task automatic run_test(input string name, input int kind, input int n, input int sbits);
        int err0;
        err0       = errors;
        cur_test   = name;
        stall_bits = sbits;
        for (int i = 0; i < n; i++) random_op(kind);
        // idle until every accepted op has written back
        @(posedge clk);
        i_valid <= 1'b0;
        i_stall <= 1'b0;
        while (data_q.size() != 0) @(posedge clk);
        $display("%s: %0d ops, %0d errors", name, n, errors - err0);
    endtask

    // write-back monitor
    always @(negedge clk) begin
        if (rst) begin
            if (o_wb_valid === 1'b1) begin
                errors++;
                $display("write-back seen while reset is held");
            end
        end else if (o_wb_valid) begin
            if (data_q.size() == 0) begin
                errors++;
                $display("write-back with no operation outstanding");
            end else begin
                if (check_data_q[0]) check_value(name_q[0], "wb_data", data_q[0], o_wb_data);
                if (write_q[0]) check_value(name_q[0], "wb_reg", 32'(reg_q[0]), 32'(o_wb_reg));
                check_value(name_q[0], "wb_reg_write", 32'(write_q[0]), 32'(o_wb_reg_write));
                check_value(name_q[0], "exc", 32'(exc_q[0]), 32'(o_exc));
                if (exc_q[0]) check_value(name_q[0], "cause", 32'(cause_q[0]), 32'(o_exc_cause));
                void'(name_q.pop_front());
                void'(data_q.pop_front());
                void'(reg_q.pop_front());
                void'(write_q.pop_front());
                void'(exc_q.pop_front());
                void'(cause_q.pop_front());
                void'(check_data_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d write-backs outstanding",
                     cycles, data_q.size());
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        i_valid = 1'b0;
        i_stall = 1'b0;
        i_op = '0;
        i_rs_val = '0;
        i_rt_val = '0;
        i_imm = '0;
        i_use_imm = 1'b0;
        i_target = '0;
        i_pc = '0;
        i_size = '0;
        i_load_sign = 1'b0;
        // memory comes out of reset as zeros
        for (int i = 0; i < MEM_WORDS; i++) model_mem[i] = '0;
        // reset is surely raised by the first edge
        @(posedge clk);
        while (rst) @(posedge clk);
        run_test("alu", 0, N_ALU, 3);
        run_test("link_overflow", 1, N_LINK, 3);
        run_test("store_load", 2, N_MEM, 3);
        run_test("misaligned", 3, N_MIS, 3);
        run_test("stall", 4, N_STALL, 1);
        $display("done: %0d ops, %0d checks, %0d errors", ops_done, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/alu_pkg.sv
/* execute-side constants; the sixteen opcodes fill the whole 4-bit space
   cause codes are shared with the memory stage */
package alu_pkg;

    // datapath widths
    localparam int WORD_W = 32;
    localparam int REG_W  = 5;
    localparam int OP_W   = 4;

    // jump-and-link always writes this register
    localparam logic [REG_W-1:0] LINK_REG = 5'd31;

    // arithmetic and logic
    localparam logic [OP_W-1:0] OP_ADD   = 4'd0;
    localparam logic [OP_W-1:0] OP_ADDU  = 4'd1;
    localparam logic [OP_W-1:0] OP_SUB   = 4'd2;
    localparam logic [OP_W-1:0] OP_SUBU  = 4'd3;
    localparam logic [OP_W-1:0] OP_AND   = 4'd4;
    localparam logic [OP_W-1:0] OP_OR    = 4'd5;
    localparam logic [OP_W-1:0] OP_XOR   = 4'd6;
    localparam logic [OP_W-1:0] OP_NOR   = 4'd7;
    // shifts take their amount from the immediate
    localparam logic [OP_W-1:0] OP_SLL   = 4'd8;
    localparam logic [OP_W-1:0] OP_SRL   = 4'd9;
    localparam logic [OP_W-1:0] OP_SRA   = 4'd10;
    // set-less-than gives 0 or 1
    localparam logic [OP_W-1:0] OP_SLT   = 4'd11;
    localparam logic [OP_W-1:0] OP_SLTU  = 4'd12;
    localparam logic [OP_W-1:0] OP_LINK  = 4'd13;
    // memory access, address is rs plus immediate
    localparam logic [OP_W-1:0] OP_LOAD  = 4'd14;
    localparam logic [OP_W-1:0] OP_STORE = 4'd15;

    // shift amount field inside the immediate
    localparam int SHAMT_LSB = 6;
    localparam int SHAMT_MSB = 10;

    // return address offset for link
    localparam logic [WORD_W-1:0] PC_STEP = 32'd4;

    // exception causes
    localparam int CAUSE_W = 2;
    localparam logic [CAUSE_W-1:0] CAUSE_NONE       = 2'd0;
    localparam logic [CAUSE_W-1:0] CAUSE_OVERFLOW   = 2'd1;
    // raised in the memory stage only
    localparam logic [CAUSE_W-1:0] CAUSE_MISALIGNED = 2'd2;

endpackage

// File: verilog/data_memory.sv
/* read is asynchronous, write lands on the clock edge
   reset zeroes every word in a single cycle */
`timescale 1ns/1ps

module data_memory (
    input  logic                       clk,
    input  logic                       i_reset,
    input  logic                       i_write,
    input  logic [mem_pkg::MEM_AW-1:0] i_addr,
    input  logic [alu_pkg::WORD_W-1:0] i_wdata,
    output logic [alu_pkg::WORD_W-1:0] o_rdata
);
    import alu_pkg::*;
    import mem_pkg::*;

    logic [WORD_W-1:0] mem [MEM_WORDS];

    // clear sweep on reset, otherwise one word per write
    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (i_write) begin
            mem[i_addr] <= i_wdata;
        end
    end

    // same-cycle read for load extract and store merge
    assign o_rdata = mem[i_addr];

endmodule

// File: verilog/ex_mem_register.sv
/* holds its contents while i_stall is high
   an overflowing op leaves here with no register write and CAUSE_OVERFLOW */
`timescale 1ns/1ps

module ex_mem_register (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_stall,
    input  logic                        i_valid,
    input  logic [alu_pkg::OP_W-1:0]    i_op,
    input  logic [alu_pkg::WORD_W-1:0]  i_result,
    input  logic [alu_pkg::WORD_W-1:0]  i_store_data,
    input  logic [alu_pkg::REG_W-1:0]   i_dest,
    input  logic                        i_reg_write,
    input  logic                        i_overflow,
    input  logic [mem_pkg::SIZE_W-1:0]  i_size,
    input  logic                        i_load_sign,
    output logic                        o_valid,
    output logic [alu_pkg::OP_W-1:0]    o_op,
    output logic [alu_pkg::WORD_W-1:0]  o_addr,
    output logic [alu_pkg::WORD_W-1:0]  o_store_data,
    output logic [alu_pkg::REG_W-1:0]   o_dest,
    output logic                        o_reg_write,
    output logic [alu_pkg::CAUSE_W-1:0] o_cause,
    output logic [mem_pkg::SIZE_W-1:0]  o_size,
    output logic                        o_load_sign
);
    import alu_pkg::*;

    // control half, the squash happens here
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_valid     <= 1'b0;
            o_reg_write <= 1'b0;
            o_cause     <= CAUSE_NONE;
        end else if (!i_stall) begin
            o_valid     <= i_valid;
            o_reg_write <= i_valid & i_reg_write & ~i_overflow;
            o_cause     <= (i_valid && i_overflow) ? CAUSE_OVERFLOW : CAUSE_NONE;
        end
    end

    // payload half
    // o_addr is the ALU result, which is the address for loads and stores
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_op         <= i_op;
            o_addr       <= i_result;
            o_store_data <= i_store_data;
            o_dest       <= i_dest;
            o_size       <= i_size;
            o_load_sign  <= i_load_sign;
        end
    end

endmodule

// File: verilog/execute_stage.sv
/* purely combinational, result valid in the same cycle as the operands
   overflow is reported only for signed add and subtract */
`timescale 1ns/1ps

module execute_stage (
    input  logic [alu_pkg::OP_W-1:0]   i_op,
    input  logic [alu_pkg::WORD_W-1:0] i_rs_val,
    input  logic [alu_pkg::WORD_W-1:0] i_rt_val,
    input  logic [alu_pkg::WORD_W-1:0] i_imm,
    input  logic                       i_use_imm,
    input  logic [alu_pkg::WORD_W-1:0] i_pc,
    input  logic [alu_pkg::REG_W-1:0]  i_target,
    output logic [alu_pkg::WORD_W-1:0] o_result,
    output logic [alu_pkg::WORD_W-1:0] o_store_data,
    output logic [alu_pkg::REG_W-1:0]  o_dest,
    output logic                       o_reg_write,
    output logic                       o_overflow
);
    import alu_pkg::*;

    logic                         is_shift;
    logic [SHAMT_MSB-SHAMT_LSB:0] shamt;
    logic [WORD_W-1:0]            op_a;
    logic [WORD_W-1:0]            op_b;
    logic [WORD_W-1:0]            sum;
    logic [WORD_W-1:0]            diff;
    logic [WORD_W-1:0]            mem_addr;
    logic [WORD_W-1:0]            link_addr;
    logic                         lt_signed;
    logic                         lt_unsigned;
    logic                         add_ovf;
    logic                         sub_ovf;

    // shifts move operand b by the immediate amount
    assign is_shift = (i_op == OP_SLL) || (i_op == OP_SRL) || (i_op == OP_SRA);
    assign shamt    = i_imm[SHAMT_MSB:SHAMT_LSB];

    // operand muxes
    assign op_a = is_shift ? WORD_W'(shamt) : i_rs_val;
    assign op_b = i_use_imm ? i_imm : i_rt_val;

    assign sum  = op_a + op_b;
    assign diff = op_a - op_b;

    // comparators for set-less-than
    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    // effective address does not depend on i_use_imm
    assign mem_addr  = i_rs_val + i_imm;
    assign link_addr = i_pc + PC_STEP;

    // same operand signs and a different result sign
    assign add_ovf = (op_a[WORD_W-1] == op_b[WORD_W-1]) && (sum[WORD_W-1] != op_a[WORD_W-1]);
    // opposite operand signs and the result sign follows b
    assign sub_ovf = (op_a[WORD_W-1] != op_b[WORD_W-1]) && (diff[WORD_W-1] != op_a[WORD_W-1]);

    // result mux
    always_comb begin
        case (i_op)
            OP_ADD, OP_ADDU:   o_result = sum;
            OP_SUB, OP_SUBU:   o_result = diff;
            OP_AND:            o_result = op_a & op_b;
            OP_OR:             o_result = op_a | op_b;
            OP_XOR:            o_result = op_a ^ op_b;
            OP_NOR:            o_result = ~(op_a | op_b);
            OP_SLL:            o_result = op_b << op_a;
            OP_SRL:            o_result = op_b >> op_a;
            OP_SRA:            o_result = $unsigned($signed(op_b) >>> op_a);
            OP_SLT:            o_result = WORD_W'(lt_signed);
            OP_SLTU:           o_result = WORD_W'(lt_unsigned);
            OP_LINK:           o_result = link_addr;
            default:           o_result = mem_addr;
        endcase
    end

    assign o_store_data = i_rt_val;

    // link overrides the decoded target
    assign o_dest = (i_op == OP_LINK) ? LINK_REG : i_target;

    // stores are the only op without a register result
    assign o_reg_write = (i_op != OP_STORE);

    assign o_overflow = ((i_op == OP_ADD) && add_ovf) || ((i_op == OP_SUB) && sub_ovf);

endmodule

// File: verilog/exmem_slice.sv
/* one op may enter per non-stalled cycle, write-back follows two edges later
   i_size and i_load_sign matter only for loads and stores */
`timescale 1ns/1ps

module exmem_slice (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_valid,
    input  logic                        i_stall,
    input  logic [alu_pkg::OP_W-1:0]    i_op,
    input  logic [alu_pkg::WORD_W-1:0]  i_rs_val,
    input  logic [alu_pkg::WORD_W-1:0]  i_rt_val,
    input  logic [alu_pkg::WORD_W-1:0]  i_imm,
    input  logic                        i_use_imm,
    input  logic [alu_pkg::REG_W-1:0]   i_target,
    input  logic [alu_pkg::WORD_W-1:0]  i_pc,
    input  logic [mem_pkg::SIZE_W-1:0]  i_size,
    input  logic                        i_load_sign,
    output logic                        o_wb_valid,
    output logic                        o_wb_reg_write,
    output logic [alu_pkg::REG_W-1:0]   o_wb_reg,
    output logic [alu_pkg::WORD_W-1:0]  o_wb_data,
    output logic                        o_exc,
    output logic [alu_pkg::CAUSE_W-1:0] o_exc_cause
);
    import alu_pkg::*;
    import mem_pkg::*;

    // execute outputs
    logic [WORD_W-1:0]  ex_result;
    logic [WORD_W-1:0]  ex_store_data;
    logic [REG_W-1:0]   ex_dest;
    logic               ex_reg_write;
    logic               ex_overflow;

    // register outputs into the memory stage
    logic               mem_valid;
    logic [OP_W-1:0]    mem_op;
    logic [WORD_W-1:0]  mem_addr;
    logic [WORD_W-1:0]  mem_store_data;
    logic [REG_W-1:0]   mem_dest;
    logic               mem_reg_write;
    logic [CAUSE_W-1:0] mem_cause;
    logic [SIZE_W-1:0]  mem_size;
    logic               mem_load_sign;

    execute_stage u_execute (
        .i_op         (i_op),
        .i_rs_val     (i_rs_val),
        .i_rt_val     (i_rt_val),
        .i_imm        (i_imm),
        .i_use_imm    (i_use_imm),
        .i_pc         (i_pc),
        .i_target     (i_target),
        .o_result     (ex_result),
        .o_store_data (ex_store_data),
        .o_dest       (ex_dest),
        .o_reg_write  (ex_reg_write),
        .o_overflow   (ex_overflow)
    );

    ex_mem_register u_ex_mem (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_stall      (i_stall),
        .i_valid      (i_valid),
        .i_op         (i_op),
        .i_result     (ex_result),
        .i_store_data (ex_store_data),
        .i_dest       (ex_dest),
        .i_reg_write  (ex_reg_write),
        .i_overflow   (ex_overflow),
        .i_size       (i_size),
        .i_load_sign  (i_load_sign),
        .o_valid      (mem_valid),
        .o_op         (mem_op),
        .o_addr       (mem_addr),
        .o_store_data (mem_store_data),
        .o_dest       (mem_dest),
        .o_reg_write  (mem_reg_write),
        .o_cause      (mem_cause),
        .o_size       (mem_size),
        .o_load_sign  (mem_load_sign)
    );

    memory_stage u_memory (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_stall        (i_stall),
        .i_valid        (mem_valid),
        .i_op           (mem_op),
        .i_addr         (mem_addr),
        .i_store_data   (mem_store_data),
        .i_dest         (mem_dest),
        .i_reg_write    (mem_reg_write),
        .i_cause        (mem_cause),
        .i_size         (mem_size),
        .i_load_sign    (mem_load_sign),
        .o_wb_valid     (o_wb_valid),
        .o_wb_reg_write (o_wb_reg_write),
        .o_wb_reg       (o_wb_reg),
        .o_wb_data      (o_wb_data),
        .o_exc          (o_exc),
        .o_exc_cause    (o_exc_cause)
    );

endmodule

// File: verilog/mem_pkg.sv
/* little-endian lanes, byte 0 in the low bits of the word
   a size code of 3 is handled as a word access */
package mem_pkg;

    // access size field
    localparam int SIZE_W = 2;
    localparam logic [SIZE_W-1:0] SIZE_BYTE = 2'd0;
    localparam logic [SIZE_W-1:0] SIZE_HALF = 2'd1;
    localparam logic [SIZE_W-1:0] SIZE_WORD = 2'd2;

    // on-chip data memory geometry
    localparam int MEM_WORDS = 64;
    localparam int MEM_AW    = 6;

    // lane widths and counts
    localparam int BYTE_W          = 8;
    localparam int HALF_W          = 16;
    localparam int BYTES_PER_WORD  = 4;
    localparam int HALVES_PER_WORD = 2;

    // byte offset bits below the word address
    localparam int OFFSET_W = 2;

    // one memory word seen as bytes or as halfwords
    // index 0 is the least significant lane in both views
    typedef union packed {
        logic [BYTES_PER_WORD-1:0][BYTE_W-1:0]  bytes;
        logic [HALVES_PER_WORD-1:0][HALF_W-1:0] halves;
    } mem_word_u;

endpackage

// File: verilog/memory_stage.sv
/* o_wb_valid and o_exc are one-cycle pulses; a stalled cycle shows a bubble
   word accesses drop the two low address bits */
`timescale 1ns/1ps

module memory_stage (
    input  logic                        clk,
    input  logic                        i_reset,
    input  logic                        i_stall,
    input  logic                        i_valid,
    input  logic [alu_pkg::OP_W-1:0]    i_op,
    input  logic [alu_pkg::WORD_W-1:0]  i_addr,
    input  logic [alu_pkg::WORD_W-1:0]  i_store_data,
    input  logic [alu_pkg::REG_W-1:0]   i_dest,
    input  logic                        i_reg_write,
    input  logic [alu_pkg::CAUSE_W-1:0] i_cause,
    input  logic [mem_pkg::SIZE_W-1:0]  i_size,
    input  logic                        i_load_sign,
    output logic                        o_wb_valid,
    output logic                        o_wb_reg_write,
    output logic [alu_pkg::REG_W-1:0]   o_wb_reg,
    output logic [alu_pkg::WORD_W-1:0]  o_wb_data,
    output logic                        o_exc,
    output logic [alu_pkg::CAUSE_W-1:0] o_exc_cause
);
    import alu_pkg::*;
    import mem_pkg::*;

    logic [OFFSET_W-1:0] offset;
    logic [MEM_AW-1:0]   word_addr;
    logic                is_load;
    logic                is_store;
    logic                misaligned;
    logic [CAUSE_W-1:0]  cause;
    logic                faulted;
    logic                mem_write;
    logic [WORD_W-1:0]   rdata;
    mem_word_u           old_word;
    mem_word_u           new_word;
    logic [BYTE_W-1:0]   load_byte;
    logic [HALF_W-1:0]   load_half;
    logic                byte_ext;
    logic                half_ext;
    logic [WORD_W-1:0]   load_data;

    // split the address into word index and byte offset
    assign offset    = i_addr[OFFSET_W-1:0];
    assign word_addr = i_addr[OFFSET_W +: MEM_AW];

    assign is_load  = (i_op == OP_LOAD);
    assign is_store = (i_op == OP_STORE);

    // halfword must sit on an even byte
    assign misaligned = (is_load || is_store) && (i_size == SIZE_HALF) && offset[0];

    // an overflow from execute wins over a memory fault
    assign cause   = (i_cause != CAUSE_NONE) ? i_cause :
                     (misaligned ? CAUSE_MISALIGNED : CAUSE_NONE);
    assign faulted = (cause != CAUSE_NONE);

    // write only when the store leaves the register
    assign mem_write = i_valid & is_store & ~faulted & ~i_stall;

    data_memory u_data_memory (
        .clk     (clk),
        .i_reset (i_reset),
        .i_write (mem_write),
        .i_addr  (word_addr),
        .i_wdata (new_word),
        .o_rdata (rdata)
    );

    assign old_word = rdata;

    // store merge, replace one lane of the old word
    always_comb begin
        new_word = old_word;
        case (i_size)
            SIZE_BYTE: new_word.bytes[offset]     = i_store_data[BYTE_W-1:0];
            SIZE_HALF: new_word.halves[offset[1]] = i_store_data[HALF_W-1:0];
            default:   new_word                   = i_store_data;
        endcase
    end

    // load extract
    assign load_byte = old_word.bytes[offset];
    assign load_half = old_word.halves[offset[1]];
    assign byte_ext  = i_load_sign & load_byte[BYTE_W-1];
    assign half_ext  = i_load_sign & load_half[HALF_W-1];

    always_comb begin
        case (i_size)
            SIZE_BYTE: load_data = {{(WORD_W - BYTE_W){byte_ext}}, load_byte};
            SIZE_HALF: load_data = {{(WORD_W - HALF_W){half_ext}}, load_half};
            default:   load_data = old_word;
        endcase
    end

    // write-back control, pulses drop while stalled
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_wb_valid     <= 1'b0;
            o_wb_reg_write <= 1'b0;
            o_exc          <= 1'b0;
            o_exc_cause    <= CAUSE_NONE;
        end else if (i_stall) begin
            o_wb_valid     <= 1'b0;
            o_wb_reg_write <= 1'b0;
            o_exc          <= 1'b0;
        end else begin
            o_wb_valid     <= i_valid;
            o_wb_reg_write <= i_valid & i_reg_write & ~faulted;
            o_exc          <= i_valid & faulted;
            o_exc_cause    <= cause;
        end
    end

    // write-back payload
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_wb_reg  <= i_dest;
            o_wb_data <= is_load ? load_data : i_addr;
        end
    end

endmodule

// File: vlog.f
verilog/alu_pkg.sv
verilog/mem_pkg.sv
verilog/execute_stage.sv
verilog/ex_mem_register.sv
verilog/data_memory.sv
verilog/memory_stage.sv
verilog/exmem_slice.sv
bench/clock_gen.sv
bench/tb_exmem_slice.sv
